/* build.f */
+incdir+common
common/core_pkg.sv
verilog/pipe_reg.sv
verilog/alu_unit.sv
verilog/mul_pipe.sv
rob/reorder_buffer.sv
verilog/backend_core.sv
dv/backend_core_properties.sv
dv/backend_core_tb.sv

/* common/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath width
`define XLEN 32

// Destination register index width
`define REG_IDX_W 5

// Reorder buffer entries, the tag wraps modulo this depth
`define ROB_DEPTH 10

// Reorder buffer tag width
`define ROB_IDX_W 4

// Multiplier latency in pipeline stages
`define MUL_STAGES 3

`endif

/* common/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    // Operations accepted at issue
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_MUL = 3'd6
    } op_t;

    // Operation after it has been given a buffer entry
    typedef struct packed {
        op_t                   op;
        logic [`XLEN-1:0]      a;
        logic [`XLEN-1:0]      b;
        logic [`ROB_IDX_W-1:0] tag;
    } issue_t;

    // Multiplier stage payload
    // Product travels in lo once the cross terms are folded in
    typedef struct packed {
        logic [`XLEN-1:0]      lo;
        logic [`XLEN-1:0]      cross_a;
        logic [`XLEN-1:0]      cross_b;
        logic [`ROB_IDX_W-1:0] tag;
    } mul_req_t;

    // Result written back into the buffer
    typedef struct packed {
        logic [`ROB_IDX_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } completion_t;

endpackage

/* dv/backend_core_properties.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module backend_core_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input logic                  full,
    input logic [`ROB_IDX_W-1:0] alloc_tag,
    input logic                  commit_valid,
    input logic                  alu_done,
    input logic [`ROB_IDX_W-1:0] alu_tag,
    input logic                  mul_done,
    input logic [`ROB_IDX_W-1:0] mul_tag
);

    // Nothing retires while the cleared buffer refills
    property commit_quiet_after_clear;
        @(posedge clk) (reset || flush) |=> !commit_valid ##1 !commit_valid;
    endproperty

    // A full buffer leaves its tail where it is
    property no_alloc_when_full;
        @(posedge clk) disable iff (reset) (full && !flush) |=> $stable(alloc_tag);
    endproperty

    // Both completion ports may fire together, never for the same entry
    property distinct_completion_tags;
        @(posedge clk) disable iff (reset) (alu_done && mul_done) |-> (alu_tag != mul_tag);
    endproperty

    commit_quiet_check: assert property (commit_quiet_after_clear)
        else $error("commit_valid high within two cycles after reset or flush");

    alloc_full_check: assert property (no_alloc_when_full)
        else $error("tail moved while the reorder buffer was full");

    completion_tag_check: assert property (distinct_completion_tags)
        else $error("ALU and multiplier completed the same tag in one cycle");

endmodule

bind backend_core backend_core_properties props_i (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .full         (full),
    .alloc_tag    (alloc_tag),
    .commit_valid (commit_valid),
    .alu_done     (alu_done),
    .alu_tag      (alu_tag),
    .mul_done     (mul_done),
    .mul_tag      (mul_tag)
);

/* dv/backend_core_tb.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module backend_core_tb
    import core_pkg::*;
();

    localparam int CYCLES_PER_ROW = 20;
    localparam int TIMEOUT_BASE   = 200;
    localparam int RESET_CYCLES   = 16;
    localparam int ALU_LATENCY    = 4;
    localparam int MUL_LATENCY    = 6;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  issue_valid;
    op_t                   issue_op;
    logic [`XLEN-1:0]      issue_a;
    logic [`XLEN-1:0]      issue_b;
    logic [`REG_IDX_W-1:0] issue_rd;
    logic                  full;
    logic                  commit_valid;
    logic [`REG_IDX_W-1:0] commit_rd;
    logic [`XLEN-1:0]      commit_value;

    // Stimulus table, one entry per test in each queue
    string                 row_name  [$];
    op_t                   row_op    [$];
    logic [`REG_IDX_W-1:0] row_rd    [$];
    int                    row_gap   [$];
    bit                    row_flush [$];

    // Reference model, oldest accepted operation at the front
    string                 exp_name    [$];
    logic [`REG_IDX_W-1:0] exp_rd      [$];
    logic [`XLEN-1:0]      exp_value   [$];
    int                    exp_accept  [$];
    int                    exp_min_lat [$];

    logic [31:0] lfsr_state;
    int          cycle;
    int          timeout_limit;
    int          commit_count;

    backend_core backend_core_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_rd     (issue_rd),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            report_failure($sformatf("run did not finish within %0d cycles", timeout_limit));
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [`XLEN-1:0] random_word();
        logic [`XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < `XLEN; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[`XLEN-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic [`XLEN-1:0] expected_result(input op_t op,
                                                         input logic [`XLEN-1:0] a,
                                                         input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] prod;
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << (b % `XLEN);
            OP_MUL:  return prod[`XLEN-1:0];
            default: return 'x;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic add_row(input string name, input op_t op, input int rd,
                           input int gap, input bit flush_after);
        row_name.push_back(name);
        row_op.push_back(op);
        row_rd.push_back(rd[`REG_IDX_W-1:0]);
        row_gap.push_back(gap);
        row_flush.push_back(flush_after);
    endtask

    task automatic build_table();
        // Lone ALU operation for the latency check
        add_row("single_add", OP_ADD, 1, 10, 0);
        // Every ALU operation back to back
        add_row("alu_add", OP_ADD, 2, 0, 0);
        add_row("alu_sub", OP_SUB, 3, 0, 0);
        add_row("alu_and", OP_AND, 4, 0, 0);
        add_row("alu_or", OP_OR, 5, 0, 0);
        add_row("alu_xor", OP_XOR, 6, 0, 0);
        add_row("alu_sll", OP_SLL, 7, 8, 0);
        // ALU work right behind a multiply finishes first but retires later
        add_row("mix_mul_a", OP_MUL, 8, 0, 0);
        add_row("mix_add_after_mul", OP_ADD, 9, 0, 0);
        add_row("mix_xor", OP_XOR, 10, 1, 0);
        add_row("mix_mul_b", OP_MUL, 11, 0, 0);
        add_row("mix_sll_after_mul", OP_SLL, 12, 0, 0);
        add_row("mix_mul_c", OP_MUL, 13, 0, 0);
        add_row("mix_sub", OP_SUB, 14, 10, 0);
        // Occupancy levels off once the leading multiply starts to retire
        add_row("burst_lead_mul", OP_MUL, 20, 0, 0);
        for (int i = 0; i < 11; i++) begin
            add_row($sformatf("burst_mul_%0d", i), OP_MUL, 21 + i, (i == 10) ? 12 : 0, 0);
        end
        // Flush lands while all three multiplies are still in flight
        add_row("flush_mul_a", OP_MUL, 15, 0, 0);
        add_row("flush_mul_b", OP_MUL, 16, 0, 0);
        add_row("flush_mul_c", OP_MUL, 17, 2, 1);
        add_row("post_flush_add", OP_ADD, 18, 0, 0);
        add_row("post_flush_mul", OP_MUL, 19, 0, 0);
        add_row("post_flush_or", OP_OR, 0, 0, 0);
        add_row("post_flush_sll", OP_SLL, 31, 10, 0);
    endtask

    task automatic check_commit();
        string                 name;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      value;
        int                    latency;
        int                    min_lat;
        if (commit_valid) begin
            assert (exp_rd.size() != 0)
                else report_failure("commit_valid pulsed with no accepted operation left to retire");
            name    = exp_name.pop_front();
            rd      = exp_rd.pop_front();
            value   = exp_value.pop_front();
            // Pulse seen here is sampled by the coming edge
            latency = cycle + 1 - exp_accept.pop_front();
            min_lat = exp_min_lat.pop_front();
            assert (commit_rd === rd)
                else report_failure($sformatf("mismatch %s rd expected %0d actual %0d",
                                              name, rd, commit_rd));
            assert (commit_value === value)
                else report_failure($sformatf("mismatch %s value expected %h actual %h",
                                              name, value, commit_value));
            assert (latency >= min_lat)
                else report_failure($sformatf("%s retired %0d cycles after issue, too early",
                                              name, latency));
            // First retirement meets an empty buffer
            if (commit_count == 0) begin
                assert (latency == min_lat)
                    else report_failure($sformatf("mismatch %s latency expected %0d actual %0d",
                                                  name, min_lat, latency));
            end
            commit_count++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_commit();
        issue_valid = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic issue_row(input int r);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        next_cycle();
        // Model occupancy matches the buffer count at this point
        assert (full === (exp_rd.size() == `ROB_DEPTH))
            else report_failure($sformatf("mismatch %s full expected %0b actual %0b",
                                          row_name[r], exp_rd.size() == `ROB_DEPTH, full));
        a           = random_word();
        b           = random_word();
        issue_valid = 1'b1;
        issue_op    = row_op[r];
        issue_a     = a;
        issue_b     = b;
        issue_rd    = row_rd[r];
        // Taken at the coming edge unless the buffer is full
        if (!full && !flush) begin
            exp_name.push_back(row_name[r]);
            exp_rd.push_back(row_rd[r]);
            exp_value.push_back(expected_result(row_op[r], a, b));
            exp_accept.push_back(cycle + 1);
            exp_min_lat.push_back((row_op[r] == OP_MUL) ? MUL_LATENCY : ALU_LATENCY);
        end
        if (row_flush[r]) begin
            next_cycle();
            flush = 1'b1;
            exp_name.delete();
            exp_rd.delete();
            exp_value.delete();
            exp_accept.delete();
            exp_min_lat.delete();
        end
        repeat (row_gap[r]) next_cycle();
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = OP_ADD;
        issue_a       = '0;
        issue_b       = '0;
        issue_rd      = '0;
        lfsr_state    = 32'hff4e0c27;
        cycle         = 0;
        commit_count  = 0;
        build_table();
        timeout_limit = row_name.size() * CYCLES_PER_ROW + TIMEOUT_BASE;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        assert (!full && !commit_valid)
            else report_failure("full or commit_valid high after reset");

        for (int r = 0; r < row_name.size(); r++) begin
            issue_row(r);
        end

        // Drain, then keep watching for stray commits
        while (exp_rd.size() != 0) begin
            next_cycle();
        end
        repeat (12) next_cycle();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* rob/reorder_buffer.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module reorder_buffer
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    // Allocation
    input  logic                  issue_valid,
    input  logic [`REG_IDX_W-1:0] issue_rd,
    output logic                  alloc_fire,
    output logic [`ROB_IDX_W-1:0] alloc_tag,
    output logic                  full,

    // Completion ports
    input  logic                  alu_done,
    input  logic [`ROB_IDX_W-1:0] alu_tag,
    input  logic [`XLEN-1:0]      alu_value,
    input  logic                  mul_done,
    input  logic [`ROB_IDX_W-1:0] mul_tag,
    input  logic [`XLEN-1:0]      mul_value,

    // Commit
    output logic                  commit_valid,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic [`XLEN-1:0]      commit_value
);

    localparam int IDX_W   = `ROB_IDX_W;
    localparam int CNT_W   = $clog2(`ROB_DEPTH + 1);
    localparam int N_PORTS = 2;
    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(`ROB_DEPTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ROB_DEPTH - 1);

    logic                  busy   [`ROB_DEPTH];
    logic                  done   [`ROB_DEPTH];
    logic [`REG_IDX_W-1:0] dest   [`ROB_DEPTH];
    logic [`XLEN-1:0]      result [`ROB_DEPTH];

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             retire;

    completion_t cpl       [N_PORTS];
    logic        cpl_valid [N_PORTS];

    // Circular index step, wraps at depth rather than at a power of two
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    assign full       = (count == DEPTH);
    assign alloc_fire = issue_valid && !full && !flush;
    assign alloc_tag  = tail;

    // Head retires only once its result is in
    assign retire = busy[head] && done[head] && !flush;

    always_comb begin
        cpl_valid[0]  = alu_done;
        cpl[0].tag    = alu_tag;
        cpl[0].value  = alu_value;
        cpl_valid[1]  = mul_done;
        cpl[1].tag    = mul_tag;
        cpl[1].value  = mul_value;
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_fire) begin
                tail <= next_idx(tail);
            end
            if (retire) begin
                head <= next_idx(head);
            end
            count <= count + CNT_W'(alloc_fire) - CNT_W'(retire);
        end
    end

    // Entry status
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
            end
            // Both ports may land together, tags never collide
            for (int p = 0; p < N_PORTS; p++) begin
                if (cpl_valid[p] && busy[cpl[p].tag]) begin
                    done[cpl[p].tag] <= 1'b1;
                end
            end
            if (retire) begin
                busy[head] <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            dest[tail] <= issue_rd;
        end
        for (int p = 0; p < N_PORTS; p++) begin
            if (cpl_valid[p]) begin
                result[cpl[p].tag] <= cpl[p].value;
            end
        end
    end

    // Registered commit port
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_rd    <= dest[head];
            commit_value <= result[head];
        end
    end

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module alu_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  op_t                   in_op,
    input  logic [`XLEN-1:0]      in_a,
    input  logic [`XLEN-1:0]      in_b,
    input  logic [`ROB_IDX_W-1:0] in_tag,
    output logic                  done,
    output logic [`ROB_IDX_W-1:0] done_tag,
    output logic [`XLEN-1:0]      done_value
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic             fire;
    logic [`XLEN-1:0] result;
    completion_t      done_q;

    // Multiplies are handled by mul_pipe
    assign fire = in_valid && (in_op != OP_MUL);

    always_comb begin
        case (in_op)
            OP_ADD:  result = in_a + in_b;
            OP_SUB:  result = in_a - in_b;
            OP_AND:  result = in_a & in_b;
            OP_OR:   result = in_a | in_b;
            OP_XOR:  result = in_a ^ in_b;
            OP_SLL:  result = in_a << in_b[SHAMT_W-1:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            done <= 1'b0;
        end else begin
            done <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            done_q.tag   <= in_tag;
            done_q.value <= result;
        end
    end

    assign done_tag   = done_q.tag;
    assign done_value = done_q.value;

endmodule

/* verilog/backend_core.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module backend_core
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    // Issue side
    input  logic                  issue_valid,
    input  op_t                   issue_op,
    input  logic [`XLEN-1:0]      issue_a,
    input  logic [`XLEN-1:0]      issue_b,
    input  logic [`REG_IDX_W-1:0] issue_rd,
    output logic                  full,

    // Retire side
    output logic                  commit_valid,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic [`XLEN-1:0]      commit_value
);

    // Allocation
    logic                  alloc_fire;
    logic [`ROB_IDX_W-1:0] alloc_tag;
    issue_t                issue_in;

    // Issue register to execute units
    logic                  ex_valid;
    issue_t                ex_data;

    // Completions
    logic                  alu_done;
    logic [`ROB_IDX_W-1:0] alu_tag;
    logic [`XLEN-1:0]      alu_value;
    logic                  mul_done;
    logic [`ROB_IDX_W-1:0] mul_tag;
    logic [`XLEN-1:0]      mul_value;

    assign issue_in = '{op: issue_op, a: issue_a, b: issue_b, tag: alloc_tag};

    pipe_reg #(.payload_t(issue_t)) issue_stage (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (alloc_fire),
        .in_data   (issue_in),
        .out_valid (ex_valid),
        .out_data  (ex_data)
    );

    // Each unit picks its own operations off the shared issue register
    alu_unit alu (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (ex_valid),
        .in_op      (ex_data.op),
        .in_a       (ex_data.a),
        .in_b       (ex_data.b),
        .in_tag     (ex_data.tag),
        .done       (alu_done),
        .done_tag   (alu_tag),
        .done_value (alu_value)
    );

    mul_pipe mul (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (ex_valid),
        .in_op      (ex_data.op),
        .in_a       (ex_data.a),
        .in_b       (ex_data.b),
        .in_tag     (ex_data.tag),
        .done       (mul_done),
        .done_tag   (mul_tag),
        .done_value (mul_value)
    );

    reorder_buffer rob (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_rd     (issue_rd),
        .alloc_fire   (alloc_fire),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .alu_done     (alu_done),
        .alu_tag      (alu_tag),
        .alu_value    (alu_value),
        .mul_done     (mul_done),
        .mul_tag      (mul_tag),
        .mul_value    (mul_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

/* verilog/mul_pipe.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module mul_pipe
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  op_t                   in_op,
    input  logic [`XLEN-1:0]      in_a,
    input  logic [`XLEN-1:0]      in_b,
    input  logic [`ROB_IDX_W-1:0] in_tag,
    output logic                  done,
    output logic [`ROB_IDX_W-1:0] done_tag,
    output logic [`XLEN-1:0]      done_value
);

    localparam int HALF = `XLEN / 2;

    logic        accept;
    logic        s1_valid;
    logic        s2_valid;
    mul_req_t    s1_in;
    mul_req_t    s1_out;
    mul_req_t    s2_in;
    mul_req_t    s2_out;
    completion_t done_q;

    // Stages below are written out for a depth of three
    if (`MUL_STAGES != 3) begin : g_depth_check
        $error("mul_pipe expects a three stage multiplier");
    end

    assign accept = in_valid && (in_op == OP_MUL);

    // High by high term lands above bit XLEN-1 and is never formed
    always_comb begin
        s1_in.lo      = in_a[HALF-1:0] * in_b[HALF-1:0];
        s1_in.cross_a = in_a[`XLEN-1:HALF] * in_b[HALF-1:0];
        s1_in.cross_b = in_a[HALF-1:0] * in_b[`XLEN-1:HALF];
        s1_in.tag     = in_tag;
    end

    pipe_reg #(.payload_t(mul_req_t)) stage_1 (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (accept),
        .in_data   (s1_in),
        .out_valid (s1_valid),
        .out_data  (s1_out)
    );

    // Fold cross terms into the low product
    always_comb begin
        s2_in.lo      = s1_out.lo + ((s1_out.cross_a + s1_out.cross_b) << HALF);
        s2_in.cross_a = '0;
        s2_in.cross_b = '0;
        s2_in.tag     = s1_out.tag;
    end

    pipe_reg #(.payload_t(mul_req_t)) stage_2 (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (s1_valid),
        .in_data   (s2_in),
        .out_valid (s2_valid),
        .out_data  (s2_out)
    );

    // Completion register
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            done <= 1'b0;
        end else begin
            done <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            done_q.tag   <= s2_out.tag;
            done_q.value <= s2_out.lo;
        end
    end

    assign done_tag   = done_q.tag;
    assign done_value = done_q.value;

endmodule

/* verilog/pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg
    import core_pkg::*;
#(
    parameter type payload_t = issue_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid flag drops on reset and on flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule
